//--- logic/fma_pkg.sv
// FMA package
// Single-precision format constants, operation and rounding codes,
// and the float word view shared by the datapath stages
package fma_pkg;

  // Field widths of an IEEE 754 single
  localparam int exp_w = 8;
  localparam int man_w = 23;

  // Exponent bias and the all-ones exponent
  localparam int exp_bias = 127;
  localparam int exp_max  = 255;

  // Exact product of two 24-bit significands
  localparam int prod_w = 48;

  // Add field with carry bit on top and sticky column at bit 0
  localparam int sum_w = 76;

  // Canonical quiet NaN
  localparam logic [31:0] canon_nan = 32'h7FC0_0000;

  // Operation codes, bit 1 negates the product, bit 0 negates the addend
  localparam logic [1:0] op_fmadd  = 2'b00;
  localparam logic [1:0] op_fmsub  = 2'b01;
  localparam logic [1:0] op_fnmsub = 2'b10;
  localparam logic [1:0] op_fnmadd = 2'b11;

  // RISC-V rounding modes, codes 5 to 7 behave as RNE
  localparam logic [2:0] rm_rne = 3'd0;
  localparam logic [2:0] rm_rtz = 3'd1;
  localparam logic [2:0] rm_rdn = 3'd2;
  localparam logic [2:0] rm_rup = 3'd3;
  localparam logic [2:0] rm_rmm = 3'd4;

  // One float word, seen as raw bits or as its fields
  typedef union packed {
    logic [31:0] bits;
    struct packed {
      logic             sign;
      logic [exp_w-1:0] exp;
      logic [man_w-1:0] frac;
    } f;
  } fp32_u;

endpackage

//--- logic/fma_sequencer.sv
// FMA stage sequencer
// Walks one operation through unpack, multiply, add, normalize and round
`timescale 1ns/1ps

module fma_sequencer (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       start,
  input  logic [1:0] fma_op,
  input  logic [2:0] rounding_mode,
  output logic       busy,
  output logic       done,
  output logic       unpack_en,
  output logic       mul_en,
  output logic       add_en,
  output logic       norm_en,
  output logic       round_en,
  output logic [1:0] op,
  output logic [2:0] rm
);
  import fma_pkg::*;

  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_unpack = 3'd1;
  localparam logic [2:0] st_mul    = 3'd2;
  localparam logic [2:0] st_add    = 3'd3;
  localparam logic [2:0] st_norm   = 3'd4;
  localparam logic [2:0] st_round  = 3'd5;
  localparam logic [2:0] st_done   = 3'd6;

  logic [2:0] state;
  logic accept;

  // New work only when idle or finishing
  assign accept = start && (state == st_idle || state == st_done);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
      op    <= op_fmadd;
      rm    <= rm_rne;
    end else begin
      case (state)
        st_unpack: state <= st_mul;
        st_mul:    state <= st_add;
        st_add:    state <= st_norm;
        st_norm:   state <= st_round;
        st_round:  state <= st_done;
        default:   state <= accept ? st_unpack : st_idle;
      endcase
      // Controls stay fixed for the whole operation
      if (accept) begin
        op <= fma_op;
        rm <= rounding_mode;
      end
    end
  end

  // One strobe per working cycle
  assign unpack_en = (state == st_unpack);
  assign mul_en    = (state == st_mul);
  assign add_en    = (state == st_add);
  assign norm_en   = (state == st_norm);
  assign round_en  = (state == st_round);
  assign busy      = unpack_en | mul_en | add_en | norm_en | round_en;
  assign done      = (state == st_done);

  // ==============================
  // Protocol checks
  // ==============================
  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done);
  a_busy_done: assert property (@(posedge clk) disable iff (!reset_n) !(busy && done));
  a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0({unpack_en, mul_en, add_en, norm_en, round_en}));

endmodule

//--- logic/fma_unpack.sv
// FMA unpack stage
// Splits the three operands into fields, classifies them
// and folds in the sign changes of the operation
`timescale 1ns/1ps

module fma_unpack (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      unpack_en,
  input  logic [1:0]                op,
  input  logic [31:0]               operand_a,
  input  logic [31:0]               operand_b,
  input  logic [31:0]               operand_c,
  output logic                      sign_a, sign_b, sign_c, sign_prod,
  output logic [fma_pkg::exp_w-1:0] exp_a, exp_b, exp_c,
  output logic [fma_pkg::man_w:0]   man_a, man_b, man_c,
  output logic                      is_zero_a, is_zero_b, is_zero_c,
  output logic                      is_inf_a, is_inf_b, is_inf_c,
  output logic                      is_nan_a, is_nan_b, is_nan_c,
  output logic                      is_snan_a, is_snan_b, is_snan_c
);
  import fma_pkg::*;

  fp32_u word_a, word_b, word_c;

  assign word_a = operand_a;
  assign word_b = operand_b;
  assign word_c = operand_c;

  // Class bits as {zero, inf, nan, snan}
  // Zero exponent counts as zero, so subnormals flush here
  function automatic logic [3:0] classify(input fp32_u w);
    logic nan;
    nan = w.bits[30:0] > {exp_w'(exp_max), {man_w{1'b0}}};
    classify = {w.f.exp == '0,
                w.f.exp == exp_w'(exp_max) && w.f.frac == '0,
                nan,
                nan && !w.f.frac[man_w-1]};
  endfunction

  // Significand with hidden bit, zero for a flushed operand
  function automatic logic [man_w:0] signif(input fp32_u w);
    signif = (w.f.exp == '0) ? '0 : {1'b1, w.f.frac};
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      {is_zero_a, is_inf_a, is_nan_a, is_snan_a} <= '0;
      {is_zero_b, is_inf_b, is_nan_b, is_snan_b} <= '0;
      {is_zero_c, is_inf_c, is_nan_c, is_snan_c} <= '0;
    end else if (unpack_en) begin
      {is_zero_a, is_inf_a, is_nan_a, is_snan_a} <= classify(word_a);
      {is_zero_b, is_inf_b, is_nan_b, is_snan_b} <= classify(word_b);
      {is_zero_c, is_inf_c, is_nan_c, is_snan_c} <= classify(word_c);
    end
  end

  always_ff @(posedge clk) begin
    if (unpack_en) begin
      sign_a    <= word_a.f.sign;
      sign_b    <= word_b.f.sign;
      // Addend and product signs already carry the operation
      sign_c    <= word_c.f.sign ^ op[0];
      sign_prod <= word_a.f.sign ^ word_b.f.sign ^ op[1];
      exp_a     <= word_a.f.exp;
      exp_b     <= word_b.f.exp;
      exp_c     <= word_c.f.exp;
      man_a     <= signif(word_a);
      man_b     <= signif(word_b);
      man_c     <= signif(word_c);
    end
  end

endmodule

//--- logic/fma_special.sv
// FMA special-value resolver
// Decides NaN, infinity and signed-zero outcomes in the multiply cycle
`timescale 1ns/1ps

module fma_special (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        mul_en,
  input  logic [2:0]  rm,
  input  logic        is_zero_a, is_zero_b, is_zero_c,
  input  logic        is_inf_a, is_inf_b, is_inf_c,
  input  logic        is_nan_a, is_nan_b, is_nan_c,
  input  logic        is_snan_a, is_snan_b, is_snan_c,
  input  logic        sign_c,
  input  logic        sign_prod,
  output logic        special_hit,
  output logic [31:0] special_result,
  output logic        special_nv
);
  import fma_pkg::*;

  logic any_nan, any_snan, prod_inf, prod_zero;
  logic hit, nv;
  fp32_u res;

  assign any_nan   = is_nan_a | is_nan_b | is_nan_c;
  assign any_snan  = is_snan_a | is_snan_b | is_snan_c;
  assign prod_inf  = is_inf_a | is_inf_b;
  assign prod_zero = is_zero_a | is_zero_b;

  // Priority order, first match wins
  always_comb begin
    hit      = 1'b1;
    nv       = 1'b0;
    res.bits = canon_nan;
    if (any_nan) begin
      // Quiet NaNs pass silently
      nv = any_snan;
    end else if ((is_inf_a && is_zero_b) || (is_zero_a && is_inf_b)) begin
      nv = 1'b1;
    end else if (prod_inf && is_inf_c && (sign_prod != sign_c)) begin
      // Infinities of opposite sign
      nv = 1'b1;
    end else if (prod_inf || is_inf_c) begin
      res.f.sign = prod_inf ? sign_prod : sign_c;
      res.f.exp  = '1;
      res.f.frac = '0;
    end else if (prod_zero && is_zero_c) begin
      res.bits   = '0;
      // Negative only when both are, or on a mixed pair rounding down
      res.f.sign = (sign_prod & sign_c) | ((sign_prod ^ sign_c) & (rm == rm_rdn));
    end else begin
      hit      = 1'b0;
      res.bits = '0;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      special_hit <= 1'b0;
      special_nv  <= 1'b0;
    end else if (mul_en) begin
      special_hit <= hit;
      special_nv  <= nv;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_en) begin
      special_result <= res.bits;
    end
  end

endmodule

//--- logic/fma_mul_add.sv
// FMA multiply and align-add stages
// Exact 48-bit product, addend placed by exponent with a sticky column,
// then one signed magnitude add into the wide sum field
`timescale 1ns/1ps

module fma_mul_add (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      mul_en,
  input  logic                      add_en,
  input  logic                      sign_prod,
  input  logic                      sign_c,
  input  logic [fma_pkg::exp_w-1:0] exp_a, exp_b, exp_c,
  input  logic [fma_pkg::man_w:0]   man_a, man_b, man_c,
  input  logic                      is_zero_a, is_zero_b, is_zero_c,
  output logic [fma_pkg::sum_w-1:0] sum,
  output logic                      sum_sign,
  output logic signed [9:0]         sum_exp,
  output logic                      sum_zero
);
  import fma_pkg::*;

  // Addend LSB position when placed at the top of the field
  localparam int add_lsb = sum_w - man_w - 2;
  // Largest addend offset above the product LSB without shifting the product
  localparam int d_max = add_lsb - 1;

  logic [prod_w-1:0] prod;
  logic signed [9:0] exp_prod;
  logic prod_zero;

  logic signed [11:0] d;
  logic [sum_w-1:0] pa, ca, mag;
  logic signed [9:0] exp_ref;
  logic mag_sign;

  // Right shift, bits falling off are ORed into bit 0
  function automatic logic [sum_w-1:0] shr_sticky(input logic [sum_w-1:0] v,
                                                   input logic [11:0] sh);
    logic [sum_w-1:0] lost;
    lost = v & ~({sum_w{1'b1}} << sh);
    shr_sticky = (v >> sh) | {{(sum_w-1){1'b0}}, |lost};
  endfunction

  // ==============================
  // Multiply cycle
  // ==============================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      prod_zero <= 1'b0;
    end else if (mul_en) begin
      prod_zero <= is_zero_a | is_zero_b;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_en) begin
      prod     <= man_a * man_b;
      exp_prod <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 10'(exp_bias);
    end
  end

  // ==============================
  // Align and add
  // ==============================
  always_comb begin
    // Addend LSB offset above the product LSB
    d = $signed({4'b0000, exp_c}) - exp_prod + 12'(man_w);
    if (prod_zero || (!is_zero_c && d > d_max)) begin
      // Addend pinned at the top, product slides down
      ca      = {1'b0, man_c, {add_lsb{1'b0}}};
      pa      = prod_zero ? '0 : shr_sticky({{(sum_w-prod_w-1){1'b0}}, prod, 1'b0},
                                            12'(d - 12'(d_max)));
      exp_ref = $signed({2'b00, exp_c}) + 10'sd1;
    end else begin
      // Product LSB at bit 1, addend placed relative to it
      pa      = {{(sum_w-prod_w-1){1'b0}}, prod, 1'b0};
      ca      = shr_sticky({1'b0, man_c, {add_lsb{1'b0}}}, 12'(12'(d_max) - d));
      exp_ref = exp_prod + 10'(sum_w - prod_w);
    end
    // Larger magnitude gives the sign
    if (sign_prod == sign_c) begin
      mag      = pa + ca;
      mag_sign = sign_prod;
    end else if (pa >= ca) begin
      mag      = pa - ca;
      mag_sign = sign_prod;
    end else begin
      mag      = ca - pa;
      mag_sign = sign_c;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sum_zero <= 1'b0;
    end else if (add_en) begin
      sum_zero <= (mag == '0);
    end
  end

  // Exponent of a leading one at the carry bit
  always_ff @(posedge clk) begin
    if (add_en) begin
      sum      <= mag;
      sum_sign <= mag_sign;
      sum_exp  <= exp_ref;
    end
  end

endmodule

//--- logic/fma_norm_round.sv
// FMA normalize and round stages
// One-step leading-one shift, single rounding by mode, range limits
// and final choice between the datapath and the special result
`timescale 1ns/1ps

module fma_norm_round (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      norm_en,
  input  logic                      round_en,
  input  logic [2:0]                rm,
  input  logic [fma_pkg::sum_w-1:0] sum,
  input  logic                      sum_sign,
  input  logic signed [9:0]         sum_exp,
  input  logic                      sum_zero,
  input  logic                      special_hit,
  input  logic [31:0]               special_result,
  input  logic                      special_nv,
  output logic [31:0]               result,
  output logic                      flag_nv,
  output logic                      flag_of,
  output logic                      flag_uf,
  output logic                      flag_nx
);
  import fma_pkg::*;

  // Guard bit sits just below the 24-bit significand
  localparam int guard_pos = sum_w - man_w - 2;

  logic [6:0] lz;
  logic [sum_w-1:0] shifted;
  logic [man_w:0] mant;
  logic guard, sticky;
  logic signed [9:0] norm_exp;

  logic inexact, inc, to_max;
  logic [man_w+1:0] mant_r;
  logic signed [9:0] exp_r;

  function automatic logic [6:0] lead_zeros(input logic [sum_w-1:0] v);
    logic [6:0] n;
    logic found;
    n = '0;
    found = 1'b0;
    for (int i = sum_w - 1; i >= 0; i--) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 7'd1;
      end
    end
    lead_zeros = n;
  endfunction

  // ==============================
  // Normalize cycle
  // ==============================
  assign lz      = lead_zeros(sum);
  assign shifted = sum << lz;

  always_ff @(posedge clk) begin
    if (norm_en) begin
      mant     <= shifted[sum_w-1 -: man_w+1];
      guard    <= shifted[guard_pos];
      sticky   <= |shifted[guard_pos-1:0];
      norm_exp <= sum_exp - $signed({3'b000, lz});
    end
  end

  // ==============================
  // Round cycle
  // ==============================
  always_comb begin
    inexact = guard | sticky;
    case (rm)
      rm_rtz:  inc = 1'b0;
      rm_rdn:  inc = sum_sign & inexact;
      rm_rup:  inc = !sum_sign & inexact;
      rm_rmm:  inc = guard;
      default: inc = guard & (sticky | mant[0]);
    endcase
    mant_r = {1'b0, mant} + {{(man_w+1){1'b0}}, inc};
    // Carry out leaves a zero fraction, only the exponent moves
    exp_r  = norm_exp + $signed({9'd0, mant_r[man_w+1]});
    // Overflow saturates when rounding toward zero for this sign
    to_max = (rm == rm_rtz) || (rm == rm_rdn && !sum_sign) || (rm == rm_rup && sum_sign);
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result  <= '0;
      flag_nv <= 1'b0;
      flag_of <= 1'b0;
      flag_uf <= 1'b0;
      flag_nx <= 1'b0;
    end else if (round_en) begin
      flag_nv <= 1'b0;
      flag_of <= 1'b0;
      flag_uf <= 1'b0;
      flag_nx <= 1'b0;
      if (special_hit) begin
        result  <= special_result;
        flag_nv <= special_nv;
      end else if (sum_zero) begin
        // Exact cancellation
        result <= {rm == rm_rdn, 31'd0};
      end else if (exp_r >= exp_max) begin
        result  <= to_max ? {sum_sign, exp_w'(exp_max - 1), {man_w{1'b1}}}
                          : {sum_sign, {exp_w{1'b1}}, {man_w{1'b0}}};
        flag_of <= 1'b1;
        flag_nx <= 1'b1;
      end else if (exp_r < 1) begin
        // Below the normal range, flush
        result  <= {sum_sign, 31'd0};
        flag_uf <= 1'b1;
        flag_nx <= 1'b1;
      end else begin
        result  <= {sum_sign, exp_r[exp_w-1:0], mant_r[man_w-1:0]};
        flag_nx <= inexact;
      end
    end
  end

  // Special outcomes never report range errors
  a_special_flags: assert property (@(posedge clk) disable iff (!reset_n)
    round_en && special_hit |=> !flag_of && !flag_uf);

endmodule

//--- logic/fma_top.sv
// FMA top level
// Connects the stage sequencer to the unpack, special, multiply-add
// and normalize-round stages of the single-precision FMA
`timescale 1ns/1ps

module fma_top (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        start,
  input  logic [1:0]  fma_op,
  input  logic [2:0]  rounding_mode,
  input  logic [31:0] operand_a,
  input  logic [31:0] operand_b,
  input  logic [31:0] operand_c,
  output logic        busy,
  output logic        done,
  output logic [31:0] result,
  output logic        flag_nv,
  output logic        flag_of,
  output logic        flag_uf,
  output logic        flag_nx
);
  import fma_pkg::*;

  // Stage strobes and latched controls
  logic unpack_en, mul_en, add_en, norm_en, round_en;
  logic [1:0] op;
  logic [2:0] rm;

  // Unpacked operands
  logic sign_c, sign_prod;
  logic [exp_w-1:0] exp_a, exp_b, exp_c;
  logic [man_w:0] man_a, man_b, man_c;
  logic is_zero_a, is_zero_b, is_zero_c;
  logic is_inf_a, is_inf_b, is_inf_c;
  logic is_nan_a, is_nan_b, is_nan_c;
  logic is_snan_a, is_snan_b, is_snan_c;

  // Special-case outcome
  logic special_hit, special_nv;
  logic [31:0] special_result;

  // Aligned sum
  logic [sum_w-1:0] sum;
  logic sum_sign, sum_zero;
  logic signed [9:0] sum_exp;

  fma_sequencer u_sequencer (.*);

  // Operand signs a and b only matter through sign_prod
  fma_unpack u_unpack (.sign_a(), .sign_b(), .*);

  fma_special u_special (.*);

  fma_mul_add u_mul_add (.*);

  fma_norm_round u_norm_round (.*);

endmodule

//--- test/tb_clock.sv
// Testbench clock and reset source
// 8 ns clock, reset held low for the first 5 rising edges
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset_n
);
  localparam realtime half_period = 4ns;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

//--- test/fma_tb.sv
// FMA testbench
// Directed, special-value, range, protocol and random checks of fma_top
// against an exact integer reference model
`timescale 1ns/1ps

module fma_tb;
  import fma_pkg::*;

  localparam int n_random        = 400;
  localparam int n_directed      = 40;
  localparam int watchdog_cycles = 20 * (n_random + n_directed) + 100;
  localparam int done_limit      = 20;

  // Handy constants
  localparam logic [31:0] one   = 32'h3F80_0000;
  localparam logic [31:0] two   = 32'h4000_0000;
  localparam logic [31:0] three = 32'h4040_0000;
  localparam logic [31:0] p_inf = 32'h7F80_0000;
  localparam logic [31:0] n_inf = 32'hFF80_0000;
  localparam logic [31:0] p_max = 32'h7F7F_FFFF;
  localparam logic [31:0] n_max = 32'hFF7F_FFFF;

  logic clk, reset_n;
  logic start, busy, done;
  logic [1:0] fma_op;
  logic [2:0] rounding_mode;
  logic [31:0] operand_a, operand_b, operand_c, result;
  logic flag_nv, flag_of, flag_uf, flag_nx;
  logic [3:0] flags;

  integer seed = 10443;
  int mismatches = 0;
  int failures = 0;
  int cycles;

  // Issued operations as {op, rm, a, b, c}
  logic [100:0] pending[$];
  logic [100:0] entry;
  logic [35:0] expected;
  logic prev_done = 1'b0;

  assign flags = {flag_nv, flag_of, flag_uf, flag_nx};

  tb_clock u_clock (.clk(clk), .reset_n(reset_n));

  fma_top dut (.*);

  // ==============================
  // Reference model
  // ==============================
  function automatic logic is_nan(input logic [31:0] w);
    return w[30:23] == 8'hFF && w[22:0] != 23'd0;
  endfunction

  function automatic logic is_snan(input logic [31:0] w);
    return is_nan(w) && !w[22];
  endfunction

  function automatic logic is_inf(input logic [31:0] w);
    return w[30:23] == 8'hFF && w[22:0] == 23'd0;
  endfunction

  // Subnormals count as zero
  function automatic logic is_zero(input logic [31:0] w);
    return w[30:23] == 8'd0;
  endfunction

  // Scale by 4 for two guard bits, then move by k with sticky on bit 0
  function automatic logic [127:0] align_term(input logic [127:0] v, input int k);
    logic [127:0] w, r;
    w = v << 2;
    if (k >= 0) return w << k;
    if (-k >= 128) return {127'd0, w != 128'd0};
    r = w >> (-k);
    if ((r << (-k)) != w) r[0] = 1'b1;
    return r;
  endfunction

  // Expected {result, nv, of, uf, nx}
  function automatic logic [35:0] fma_ref(input logic [1:0] op, input logic [2:0] rm,
                                          input logic [31:0] a, b, c);
    logic sp, sc, s, pinf, pz, gd, st, inexact, inc, to_max;
    logic [2:0] mode;
    logic [127:0] tp, tc, mag, mant;
    int pe, ce, hi, base, m, e_res;
    sp   = a[31] ^ b[31] ^ op[1];
    sc   = c[31] ^ op[0];
    mode = (rm > rm_rmm) ? rm_rne : rm;
    pinf = is_inf(a) || is_inf(b);
    pz   = is_zero(a) || is_zero(b);
    // Special values by priority
    if (is_nan(a) || is_nan(b) || is_nan(c))
      return {canon_nan, is_snan(a) || is_snan(b) || is_snan(c), 3'b000};
    if ((is_inf(a) && is_zero(b)) || (is_zero(a) && is_inf(b)))
      return {canon_nan, 4'b1000};
    if (pinf && is_inf(c) && sp != sc) return {canon_nan, 4'b1000};
    if (pinf) return {sp, 8'hFF, 23'd0, 4'b0000};
    if (is_inf(c)) return {sc, 8'hFF, 23'd0, 4'b0000};
    if (pz && is_zero(c)) return {(sp & sc) | ((sp ^ sc) & (mode == rm_rdn)), 31'd0, 4'b0000};
    // Integer terms with a float as M * 2^(E-150)
    tp = pz ? 128'd0 : {104'd0, 1'b1, a[22:0]} * {104'd0, 1'b1, b[22:0]};
    tc = is_zero(c) ? 128'd0 : {104'd0, 1'b1, c[22:0]};
    pe = int'(a[30:23]) + int'(b[30:23]) - 300;
    ce = int'(c[30:23]) - 150;
    if (tp == 128'd0) begin
      base = ce;
    end else if (tc == 128'd0) begin
      base = pe;
    end else begin
      // Keep about 100 bits below the leading term
      hi   = (pe + 47 > ce + 23) ? pe + 47 : ce + 23;
      base = (pe < ce) ? pe : ce;
      if (base < hi - 100) base = hi - 100;
    end
    tp = align_term(tp, pe - base);
    tc = align_term(tc, ce - base);
    if (sp == sc) begin
      mag = tp + tc;
      s   = sp;
    end else if (tp >= tc) begin
      mag = tp - tc;
      s   = sp;
    end else begin
      mag = tc - tp;
      s   = sc;
    end
    if (mag == 128'd0) return {mode == rm_rdn, 31'd0, 4'b0000};
    m = 0;
    for (int i = 0; i < 128; i++) begin
      if (mag[i]) m = i;
    end
    e_res = base - 2 + m - 23 + 150;
    if (m >= 24) begin
      mant = mag >> (m - 23);
      gd   = mag[m - 24];
      st   = (mag & ((128'd1 << (m - 24)) - 128'd1)) != 128'd0;
    end else begin
      mant = mag << (23 - m);
      gd   = 1'b0;
      st   = 1'b0;
    end
    inexact = gd | st;
    case (mode)
      rm_rtz:  inc = 1'b0;
      rm_rdn:  inc = s & inexact;
      rm_rup:  inc = !s & inexact;
      rm_rmm:  inc = gd;
      default: inc = gd & (st | mant[0]);
    endcase
    mant = mant + {127'd0, inc};
    if (mant[24]) begin
      mant  = mant >> 1;
      e_res = e_res + 1;
    end
    if (e_res >= 255) begin
      to_max = mode == rm_rtz || (mode == rm_rdn && !s) || (mode == rm_rup && s);
      return {to_max ? {s, 8'hFE, 23'h7FFFFF} : {s, 8'hFF, 23'd0}, 4'b0101};
    end
    if (e_res < 1) return {s, 31'd0, 4'b0011};
    return {s, 8'(e_res), mant[22:0], 3'b000, inexact};
  endfunction

  // Normal operand with exponent 64..190
  function automatic logic [31:0] random_normal();
    logic [31:0] r, e;
    r = $random(seed);
    e = 32'd64 + ($unsigned($random(seed)) % 32'd127);
    return {r[31], e[7:0], r[22:0]};
  endfunction

  // ==============================
  // Stimulus tasks
  // ==============================
  // Called at a rising edge, returns at the accepting edge
  task automatic launch(input logic [1:0] op, input logic [2:0] rm,
                        input logic [31:0] a, b, c);
    fma_op        <= op;
    rounding_mode <= rm;
    operand_a     <= a;
    operand_b     <= b;
    operand_c     <= c;
    start         <= 1'b1;
    pending.push_back({op, rm, a, b, c});
    @(posedge clk);
    start <= 1'b0;
  endtask

  // Falling edges until done or the limit, busy must stay high meanwhile
  task automatic wait_done(output int n);
    int idle_seen;
    n = 0;
    idle_seen = 0;
    do begin
      @(negedge clk);
      n++;
      if (!done && busy !== 1'b1) begin
        idle_seen++;
      end
    end while (!done && n < done_limit);
    if (!done) begin
      failures++;
      $display("FAILURE at %0t: done did not arrive within %0d cycles", $time, done_limit);
    end
    if (idle_seen != 0) begin
      failures++;
      $display("FAILURE at %0t: busy was low in %0d cycles of a running operation",
               $time, idle_seen);
    end
  endtask

  task automatic run_op(input logic [1:0] op, input logic [2:0] rm, input logic [31:0] a, b, c);
    int n;
    @(posedge clk);
    launch(op, rm, a, b, c);
    wait_done(n);
    if (n != 6) begin
      failures++;
      $display("FAILURE at %0t: done came %0d cycles after start instead of 6", $time, n);
    end
  endtask

  // Also checks a hand-worked expected value
  task automatic run_known(input logic [1:0] op, input logic [2:0] rm, input logic [31:0] a, b, c,
                           input logic [31:0] want, input logic [3:0] want_flags);
    run_op(op, rm, a, b, c);
    if (result !== want || flags !== want_flags) begin
      mismatches++;
      $display("MISMATCH at %0t: directed a=%h b=%h c=%h got %h/%b want %h/%b",
               $time, a, b, c, result, flags, want, want_flags);
    end
  endtask

  // ==============================
  // Checker
  // ==============================
  always @(negedge clk) begin
    if (reset_n) begin
      if (done && prev_done) begin
        failures++;
        $display("FAILURE at %0t: done stayed high for more than one cycle", $time);
      end
      if (busy && done) begin
        failures++;
        $display("FAILURE at %0t: busy and done were high together", $time);
      end
      if (done) begin
        if (pending.size() == 0) begin
          failures++;
          $display("FAILURE at %0t: done pulsed with no operation pending", $time);
        end else begin
          entry    = pending.pop_front();
          expected = fma_ref(entry[100:99], entry[98:96], entry[95:64], entry[63:32], entry[31:0]);
          if ({result, flags} !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: op=%0d rm=%0d a=%h b=%h c=%h got %h/%b expected %h/%b",
                     $time, entry[100:99], entry[98:96], entry[95:64], entry[63:32],
                     entry[31:0], result, flags, expected[35:4], expected[3:0]);
          end
        end
      end
      prev_done = done;
    end
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("FAILURE: watchdog expired after %0d cycles, the run did not finish",
             watchdog_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    start         = 1'b0;
    fma_op        = op_fmadd;
    rounding_mode = rm_rne;
    operand_a     = '0;
    operand_b     = '0;
    operand_c     = '0;
    wait (reset_n === 1'b1);
    @(negedge clk);
    if (busy !== 1'b0 || done !== 1'b0 || result !== '0 || flags !== 4'b0000) begin
      failures++;
      $display("FAILURE at %0t: outputs were not cleared by reset", $time);
    end

    // Small integers 2*3 with 1
    run_known(op_fmadd, rm_rne, two, three, one, 32'h40E0_0000, 4'b0000);
    run_known(op_fmsub, rm_rne, two, three, one, 32'h40A0_0000, 4'b0000);
    run_known(op_fnmsub, rm_rne, two, three, one, 32'hC0A0_0000, 4'b0000);
    run_known(op_fnmadd, rm_rne, two, three, one, 32'hC0E0_0000, 4'b0000);

    // NaN, infinity and zero cases
    run_known(op_fmadd, rm_rne, 32'h7FC1_2345, one, one, canon_nan, 4'b0000);
    run_known(op_fmadd, rm_rne, one, one, 32'h7F80_0001, canon_nan, 4'b1000);
    run_known(op_fmadd, rm_rne, 32'h0000_0000, p_inf, one, canon_nan, 4'b1000);
    run_known(op_fmsub, rm_rne, p_inf, one, p_inf, canon_nan, 4'b1000);
    run_known(op_fmadd, rm_rne, two, three, n_inf, n_inf, 4'b0000);
    run_known(op_fmadd, rm_rne, 32'h0000_0000, three, 32'h40E0_0000, 32'h40E0_0000, 4'b0000);
    run_known(op_fmadd, rm_rne, 32'h8000_0000, one, 32'h8000_0000, 32'h8000_0000, 4'b0000);
    run_known(op_fmadd, rm_rne, 32'h8000_0000, one, 32'h0000_0000, 32'h0000_0000, 4'b0000);
    run_known(op_fmadd, rm_rdn, 32'h8000_0000, one, 32'h0000_0000, 32'h8000_0000, 4'b0000);

    // Overflow of 2^127 * 2 in each mode
    run_known(op_fmadd, rm_rne, 32'h7F00_0000, two, 32'h0, p_inf, 4'b0101);
    run_known(op_fmadd, rm_rtz, 32'h7F00_0000, two, 32'h0, p_max, 4'b0101);
    run_known(op_fmadd, rm_rdn, 32'h7F00_0000, two, 32'h0, p_max, 4'b0101);
    run_known(op_fmadd, rm_rup, 32'h7F00_0000, two, 32'h0, p_inf, 4'b0101);
    run_known(op_fmadd, rm_rmm, 32'h7F00_0000, two, 32'h0, p_inf, 4'b0101);
    run_known(op_fmadd, rm_rdn, 32'hFF00_0000, two, 32'h0, n_inf, 4'b0101);
    run_known(op_fmadd, rm_rup, 32'hFF00_0000, two, 32'h0, n_max, 4'b0101);

    // Underflow of 2^-63 * 2^-64
    run_known(op_fmadd, rm_rne, 32'h2000_0000, 32'h1F80_0000, 32'h0, 32'h0000_0000, 4'b0011);
    run_known(op_fmadd, rm_rne, 32'hA000_0000, 32'h1F80_0000, 32'h0, 32'h8000_0000, 4'b0011);

    // Exact cancellation 2*3 - 6
    run_known(op_fmsub, rm_rne, two, three, 32'h40C0_0000, 32'h0000_0000, 4'b0000);
    run_known(op_fmsub, rm_rdn, two, three, 32'h40C0_0000, 32'h8000_0000, 4'b0000);

    // Start in the done cycle is taken
    @(posedge clk);
    launch(op_fmadd, rm_rne, two, three, one);
    repeat (5) @(posedge clk);
    launch(op_fmsub, rm_rup, two, three, one);
    wait_done(cycles);
    if (cycles != 6) begin
      failures++;
      $display("FAILURE at %0t: start in the done cycle was not accepted", $time);
    end

    // Start while busy is ignored, new controls and operand must not be taken
    @(posedge clk);
    launch(op_fnmadd, rm_rtz, two, three, one);
    repeat (2) @(posedge clk);
    operand_a     <= 32'h42C8_0000;
    fma_op        <= op_fmadd;
    rounding_mode <= rm_rup;
    start         <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_done(cycles);
    if (cycles != 3) begin
      failures++;
      $display("FAILURE at %0t: start while busy changed the operation timing", $time);
    end
    repeat (8) @(negedge clk);

    // Random normal operands over all modes
    for (int i = 0; i < n_random; i++) begin
      run_op(2'($random(seed)), 3'(i % 5), random_normal(), random_normal(), random_normal());
    end

    repeat (10) @(negedge clk);
    if (pending.size() != 0) begin
      failures++;
      $display("FAILURE: %0d operations never signalled done", pending.size());
    end
    $display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
logic/fma_pkg.sv
logic/fma_sequencer.sv
logic/fma_unpack.sv
logic/fma_special.sv
logic/fma_mul_add.sv
logic/fma_norm_round.sv
logic/fma_top.sv
test/tb_clock.sv
test/fma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fma_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
